// File: list.f
+incdir+source
source/hzd_pkg.sv
source/hzd_ifs.sv
source/hzd_scoreboard.sv
source/hzd_data_hazard.sv
source/hzd_ctrl_hazard.sv
source/hzd_detector.sv
verification/hzd_tb.sv

// File: run.sh
#!/bin/sh
# compile with Verilator, run, and decide the result from the simulation output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f list.f --top-module hzd_tb -o hzd_sim &&
./obj_dir/hzd_sim | grep -q "STATUS: PASS" &&
echo "simulation passed" ||
{
  echo "simulation failed"
  exit 1
}

// File: source/hzd_ctrl_hazard.sv
// serialization is pessimistic: csr and long ops wait for every in-flight instruction
`include "hzd_defs.svh"

module hzd_ctrl_hazard
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  issue_if.ctrl_mp issue,
  disp_if.ctrl_mp  disp,
  input  logic     cmd_full_i,
  input  logic     credits_full_i,
  input  logic     credits_empty_i,
  input  logic     idiv_ready_i,
  input  logic     fdiv_ready_i,
  input  logic     mem_ready_i,
  input  logic     ptw_busy_i,
  output logic     ctrl_haz_o,
  output logic     struct_haz_o
);

  logic [`HZD_DEP_DEPTH-1:0] instr_v_r;
  logic [`HZD_DEP_DEPTH-1:0] mem_v_r;
  logic                      in_flight;
  logic                      mem_in_flight;
  logic                      fence_haz;
  logic                      credit_haz;
  logic                      serial_haz;

  // one bit per execution stage, same timing as the dependency record
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      instr_v_r <= '0;
      mem_v_r   <= '0;
    end
    else
    begin
      instr_v_r <= {instr_v_r[`HZD_DEP_DEPTH-2:0], disp.v};
      mem_v_r   <= {mem_v_r[`HZD_DEP_DEPTH-2:0], disp.v & disp.mem_v};
    end
  end

  assign in_flight     = |instr_v_r;
  assign mem_in_flight = |mem_v_r;

  // fence drains memory traffic and all outstanding credits
  assign fence_haz  = issue.fence_v & (~credits_empty_i | mem_in_flight | ~mem_ready_i);
  assign credit_haz = issue.mem_v & credits_full_i;
  assign serial_haz = (issue.csr_v | issue.long_v) & in_flight;

  assign ctrl_haz_o = fence_haz | credit_haz | serial_haz;

  // long ops may land on either divider, so both must be free
  assign struct_haz_o = ptw_busy_i
                        | cmd_full_i
                        | (issue.mem_v & ~mem_ready_i)
                        | (issue.long_v & (~idiv_ready_i | ~fdiv_ready_i));

  // the walker owns the pipe while busy, so nothing may have dispatched
  a_no_disp_ptw: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(disp.v && ptw_busy_i))
    else $error("dispatch while page table walker is busy");

endmodule

// File: source/hzd_data_hazard.sv
// forwarding is assumed from every stage not listed as a hazard; x0 is dropped on entry
`include "hzd_defs.svh"

module hzd_data_hazard
  import hzd_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  issue_if.data_mp                   issue,
  disp_if.data_mp                    disp,
  input  logic                       iwb_late_v_i,
  input  logic [`HZD_REG_ADDR_W-1:0] iwb_rd_i,
  input  logic                       fwb_late_v_i,
  input  logic [`HZD_REG_ADDR_W-1:0] fwb_rd_i,
  output logic                       data_haz_o
);

  localparam int depth_lp = `HZD_DEP_DEPTH;

  rv_rtype_s  isd_r;
  rv_r4type_s isd_r4;
  rv_rtype_s  disp_r;

  // dependency record, stage 0 is the youngest
  logic [`HZD_REG_ADDR_W-1:0] rd_r   [depth_lp];
  logic [`HZD_PIPE_W-1:0]     pipe_r [depth_lp];
  logic [depth_lp-1:0]        iw_r;
  logic [depth_lp-1:0]        fw_r;
  logic [depth_lp-1:0]        iwb_haz;
  logic [depth_lp-1:0]        fwb_haz;
  logic                       rec_haz;
  logic                       sb_haz;

  logic                       score_int_v;
  logic                       score_fp_v;
  logic [1:0]                 irs_match;
  logic                       ird_match;
  logic [2:0]                 frs_match;
  logic                       frd_match;

  // pipes whose integer result is not yet forwardable in a given stage
  function automatic logic int_haz_f(input int stage, input logic [`HZD_PIPE_W-1:0] pipe);
    logic haz;
    case (stage)
      0: haz = pipe inside {`HZD_PIPE_AUX, `HZD_PIPE_MUL, `HZD_PIPE_MEM_EARLY, `HZD_PIPE_MEM_FINAL};
      1: haz = pipe inside {`HZD_PIPE_MUL, `HZD_PIPE_MEM_FINAL};
      default: haz = 1'b0;
    endcase
    return haz;
  endfunction

  // same for floating point, fma stays busy one stage longer
  function automatic logic fp_haz_f(input int stage, input logic [`HZD_PIPE_W-1:0] pipe);
    logic haz;
    case (stage)
      0: haz = pipe inside {`HZD_PIPE_AUX, `HZD_PIPE_MEM_EARLY, `HZD_PIPE_MEM_FINAL, `HZD_PIPE_FMA};
      1: haz = pipe inside {`HZD_PIPE_MEM_FINAL, `HZD_PIPE_FMA};
      2: haz = (pipe == `HZD_PIPE_FMA);
      default: haz = 1'b0;
    endcase
    return haz;
  endfunction

  assign isd_r  = issue.instr.rtype;
  assign isd_r4 = issue.instr.r4type;
  assign disp_r = disp.instr.rtype;

  // writes to x0 never enter the record or the scoreboard
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      iw_r <= '0;
      fw_r <= '0;
    end
    else
    begin
      iw_r <= {iw_r[depth_lp-2:0], disp.v & disp.irf_w & (disp_r.rd_addr != '0)};
      fw_r <= {fw_r[depth_lp-2:0], disp.v & disp.frf_w};
    end
  end

  // rd and pipe class shift alongside the write valids
  always_ff @(posedge clk_i)
  begin
    rd_r[0]   <= disp_r.rd_addr;
    pipe_r[0] <= disp.pipe;
    for (int i = 1; i < depth_lp; i++)
    begin
      rd_r[i]   <= rd_r[i-1];
      pipe_r[i] <= pipe_r[i-1];
    end
  end

  always_comb
  begin
    rec_haz = 1'b0;
    for (int i = 0; i < depth_lp; i++)
    begin
      iwb_haz[i] = iw_r[i] & int_haz_f(i, pipe_r[i]);
      fwb_haz[i] = fw_r[i] & fp_haz_f(i, pipe_r[i]);
      rec_haz |= iwb_haz[i] & issue.irs1_v & (isd_r.rs1_addr == rd_r[i]);
      rec_haz |= iwb_haz[i] & issue.irs2_v & (isd_r.rs2_addr == rd_r[i]);
      rec_haz |= fwb_haz[i] & issue.frs1_v & (isd_r.rs1_addr == rd_r[i]);
      rec_haz |= fwb_haz[i] & issue.frs2_v & (isd_r.rs2_addr == rd_r[i]);
      rec_haz |= fwb_haz[i] & issue.frs3_v & (isd_r4.rs3_addr == rd_r[i]);
    end
  end

  // long ops score their destination until the late writeback returns
  assign score_int_v = disp.v & disp.irf_w & (disp.pipe == `HZD_PIPE_LONG)
                       & (disp_r.rd_addr != '0);
  assign score_fp_v  = disp.v & disp.frf_w & (disp.pipe == `HZD_PIPE_LONG);

  hzd_scoreboard #(.num_rs_p(2)) u_int_sb
  (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .score_v_i  (score_int_v),
    .score_rd_i (disp_r.rd_addr),
    .clear_v_i  (iwb_late_v_i),
    .clear_rd_i (iwb_rd_i),
    .rs_i       ({isd_r.rs2_addr, isd_r.rs1_addr}),
    .rd_i       (isd_r.rd_addr),
    .rs_match_o (irs_match),
    .rd_match_o (ird_match)
  );

  hzd_scoreboard #(.num_rs_p(3)) u_fp_sb
  (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .score_v_i  (score_fp_v),
    .score_rd_i (disp_r.rd_addr),
    .clear_v_i  (fwb_late_v_i),
    .clear_rd_i (fwb_rd_i),
    .rs_i       ({isd_r4.rs3_addr, isd_r.rs2_addr, isd_r.rs1_addr}),
    .rd_i       (isd_r.rd_addr),
    .rs_match_o (frs_match),
    .rd_match_o (frd_match)
  );

  // raw on pending sources, waw on a pending destination
  assign sb_haz = (|(irs_match & {issue.irs2_v, issue.irs1_v}))
                  | (issue.iwb_v & ird_match)
                  | (|(frs_match & {issue.frs3_v, issue.frs2_v, issue.frs1_v}))
                  | (issue.fwb_v & frd_match);

  assign data_haz_o = rec_haz | sb_haz;

endmodule

// File: source/hzd_defs.svh
// pipe class codes must match the decoder encoding; widths assume 32-entry register files
`ifndef HZD_DEFS_SVH
`define HZD_DEFS_SVH

// register file and instruction geometry
`define HZD_REG_ADDR_W 5
`define HZD_NUM_REGS   32
`define HZD_INSTR_W    32

// execution stages tracked after dispatch
`define HZD_DEP_DEPTH  3

// pipe class of a dispatched instruction
`define HZD_PIPE_W         3
`define HZD_PIPE_INT       3'd0
`define HZD_PIPE_CTL       3'd1
`define HZD_PIPE_AUX       3'd2
`define HZD_PIPE_MEM_EARLY 3'd3
`define HZD_PIPE_MEM_FINAL 3'd4
`define HZD_PIPE_MUL       3'd5
`define HZD_PIPE_FMA       3'd6
// long class covers ops that write back through the late path
`define HZD_PIPE_LONG      3'd7

`endif

// File: source/hzd_detector.sv
// disp_v_i is trusted to follow dispatch_v_o; both outputs are combinational from the inputs
`include "hzd_defs.svh"

module hzd_detector
  import hzd_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [`HZD_INSTR_W-1:0]    isd_instr_i,
  input  logic                       isd_irs1_v_i,
  input  logic                       isd_irs2_v_i,
  input  logic                       isd_frs1_v_i,
  input  logic                       isd_frs2_v_i,
  input  logic                       isd_frs3_v_i,
  input  logic                       isd_iwb_v_i,
  input  logic                       isd_fwb_v_i,
  input  logic                       isd_mem_v_i,
  input  logic                       isd_fence_v_i,
  input  logic                       isd_csr_v_i,
  input  logic                       isd_long_v_i,
  input  logic                       disp_v_i,
  input  logic [`HZD_INSTR_W-1:0]    disp_instr_i,
  input  logic [`HZD_PIPE_W-1:0]     disp_pipe_i,
  input  logic                       disp_irf_w_i,
  input  logic                       disp_frf_w_i,
  input  logic                       disp_mem_v_i,
  input  logic                       iwb_late_v_i,
  input  logic [`HZD_REG_ADDR_W-1:0] iwb_rd_i,
  input  logic                       fwb_late_v_i,
  input  logic [`HZD_REG_ADDR_W-1:0] fwb_rd_i,
  input  logic                       cmd_full_i,
  input  logic                       credits_full_i,
  input  logic                       credits_empty_i,
  input  logic                       idiv_ready_i,
  input  logic                       fdiv_ready_i,
  input  logic                       mem_ready_i,
  input  logic                       ptw_busy_i,
  input  logic                       irq_pending_i,
  output logic                       dispatch_v_o,
  output logic                       interrupt_v_o
);

  logic data_haz;
  logic ctrl_haz;
  logic struct_haz;

  issue_if isd_if ();
  disp_if  dsp_if ();

  assign isd_if.instr   = rv_instr_u'(isd_instr_i);
  assign isd_if.irs1_v  = isd_irs1_v_i;
  assign isd_if.irs2_v  = isd_irs2_v_i;
  assign isd_if.frs1_v  = isd_frs1_v_i;
  assign isd_if.frs2_v  = isd_frs2_v_i;
  assign isd_if.frs3_v  = isd_frs3_v_i;
  assign isd_if.iwb_v   = isd_iwb_v_i;
  assign isd_if.fwb_v   = isd_fwb_v_i;
  assign isd_if.mem_v   = isd_mem_v_i;
  assign isd_if.fence_v = isd_fence_v_i;
  assign isd_if.csr_v   = isd_csr_v_i;
  assign isd_if.long_v  = isd_long_v_i;

  assign dsp_if.v     = disp_v_i;
  assign dsp_if.instr = rv_instr_u'(disp_instr_i);
  assign dsp_if.pipe  = disp_pipe_i;
  assign dsp_if.irf_w = disp_irf_w_i;
  assign dsp_if.frf_w = disp_frf_w_i;
  assign dsp_if.mem_v = disp_mem_v_i;

  hzd_data_hazard u_data
  (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .issue        (isd_if.data_mp),
    .disp         (dsp_if.data_mp),
    .iwb_late_v_i (iwb_late_v_i),
    .iwb_rd_i     (iwb_rd_i),
    .fwb_late_v_i (fwb_late_v_i),
    .fwb_rd_i     (fwb_rd_i),
    .data_haz_o   (data_haz)
  );

  hzd_ctrl_hazard u_ctrl
  (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .issue           (isd_if.ctrl_mp),
    .disp            (dsp_if.ctrl_mp),
    .cmd_full_i      (cmd_full_i),
    .credits_full_i  (credits_full_i),
    .credits_empty_i (credits_empty_i),
    .idiv_ready_i    (idiv_ready_i),
    .fdiv_ready_i    (fdiv_ready_i),
    .mem_ready_i     (mem_ready_i),
    .ptw_busy_i      (ptw_busy_i),
    .ctrl_haz_o      (ctrl_haz),
    .struct_haz_o    (struct_haz)
  );

  // any hazard holds the instruction at issue
  assign dispatch_v_o  = ~(data_haz | ctrl_haz | struct_haz);
  // interrupts wait until the page table walker is idle
  assign interrupt_v_o = irq_pending_i & ~ptw_busy_i;

endmodule

// File: source/hzd_ifs.sv
// all fields are same-cycle levels with no handshake; the producer keeps them stable per cycle
`include "hzd_defs.svh"

// instruction waiting at issue
interface issue_if
  import hzd_pkg::*;
();
  rv_instr_u instr;
  logic      irs1_v;
  logic      irs2_v;
  logic      frs1_v;
  logic      frs2_v;
  logic      frs3_v;
  logic      iwb_v;
  logic      fwb_v;
  logic      mem_v;
  logic      fence_v;
  logic      csr_v;
  logic      long_v;

  modport data_mp (input instr, irs1_v, irs2_v, frs1_v, frs2_v, frs3_v, iwb_v, fwb_v);
  modport ctrl_mp (input mem_v, fence_v, csr_v, long_v);
endinterface

// instruction leaving issue this cycle
interface disp_if
  import hzd_pkg::*;
();
  logic                   v;
  rv_instr_u              instr;
  logic [`HZD_PIPE_W-1:0] pipe;
  logic                   irf_w;
  logic                   frf_w;
  logic                   mem_v;

  modport data_mp (input v, instr, pipe, irf_w, frf_w);
  modport ctrl_mp (input v, mem_v);
endinterface

// File: source/hzd_pkg.sv
// instruction views cover only the fields the hazard logic reads; immediates are not decoded
`include "hzd_defs.svh"

package hzd_pkg;

  // standard register-register layout
  typedef struct packed
  {
    logic [6:0]                 funct7;
    logic [`HZD_REG_ADDR_W-1:0] rs2_addr;
    logic [`HZD_REG_ADDR_W-1:0] rs1_addr;
    logic [2:0]                 funct3;
    logic [`HZD_REG_ADDR_W-1:0] rd_addr;
    logic [6:0]                 opcode;
  } rv_rtype_s;

  // fused multiply-add layout, third source sits where funct7 was
  typedef struct packed
  {
    logic [`HZD_REG_ADDR_W-1:0] rs3_addr;
    logic [1:0]                 fmt;
    logic [`HZD_REG_ADDR_W-1:0] rs2_addr;
    logic [`HZD_REG_ADDR_W-1:0] rs1_addr;
    logic [2:0]                 rm;
    logic [`HZD_REG_ADDR_W-1:0] rd_addr;
    logic [6:0]                 opcode;
  } rv_r4type_s;

  // one instruction word, read through either layout
  typedef union packed
  {
    rv_rtype_s  rtype;
    rv_r4type_s r4type;
  } rv_instr_u;

endpackage

// File: source/hzd_scoreboard.sv
// clear must only target a pending register; a same-edge score and clear leaves it pending
`include "hzd_defs.svh"

module hzd_scoreboard
#(
  parameter int num_rs_p = 2
)
(
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  logic                                    score_v_i,
  input  logic [`HZD_REG_ADDR_W-1:0]              score_rd_i,
  input  logic                                    clear_v_i,
  input  logic [`HZD_REG_ADDR_W-1:0]              clear_rd_i,
  input  logic [num_rs_p-1:0][`HZD_REG_ADDR_W-1:0] rs_i,
  input  logic [`HZD_REG_ADDR_W-1:0]              rd_i,
  output logic [num_rs_p-1:0]                     rs_match_o,
  output logic                                    rd_match_o
);

  logic [`HZD_NUM_REGS-1:0] pending_r;
  logic [`HZD_NUM_REGS-1:0] pending_n;

  // clear first so a simultaneous score wins
  always_comb
  begin
    pending_n = pending_r;
    if (clear_v_i)
      pending_n[clear_rd_i] = 1'b0;
    if (score_v_i)
      pending_n[score_rd_i] = 1'b1;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      pending_r <= '0;
    else
      pending_r <= pending_n;
  end

  // lookups see only registered state
  always_comb
  begin
    for (int i = 0; i < num_rs_p; i++)
      rs_match_o[i] = pending_r[rs_i[i]];
    rd_match_o = pending_r[rd_i];
  end

  // a late writeback must belong to an earlier score
  a_clear_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    clear_v_i |-> pending_r[clear_rd_i])
    else $error("late writeback clears register %0d that is not pending", clear_rd_i);

endmodule

// File: verification/hzd_tb.sv
// one table row per clock after reset; expected levels assume the three-stage record and env_idle
`include "hzd_defs.svh"

module hzd_tb
  import hzd_pkg::*;
();

  localparam int row_limit     = 64;
  localparam int reset_timeout = 8;

  // issue flags, same order as the concatenation in drive_row
  localparam logic [10:0] f_none  = 11'h000;
  localparam logic [10:0] f_irs1  = 11'h400;
  localparam logic [10:0] f_irs2  = 11'h200;
  localparam logic [10:0] f_frs1  = 11'h100;
  localparam logic [10:0] f_frs2  = 11'h080;
  localparam logic [10:0] f_frs3  = 11'h040;
  localparam logic [10:0] f_iwb   = 11'h020;
  localparam logic [10:0] f_fwb   = 11'h010;
  localparam logic [10:0] f_mem   = 11'h008;
  localparam logic [10:0] f_fence = 11'h004;
  localparam logic [10:0] f_csr   = 11'h002;
  localparam logic [10:0] f_long  = 11'h001;

  // environment levels
  localparam logic [7:0] e_cmd_full   = 8'h80;
  localparam logic [7:0] e_cred_full  = 8'h40;
  localparam logic [7:0] e_cred_empty = 8'h20;
  localparam logic [7:0] e_idiv       = 8'h10;
  localparam logic [7:0] e_fdiv       = 8'h08;
  localparam logic [7:0] e_mem_ready  = 8'h04;
  localparam logic [7:0] e_ptw        = 8'h02;
  localparam logic [7:0] e_irq        = 8'h01;
  localparam logic [7:0] env_idle     = e_cred_empty | e_idiv | e_fdiv | e_mem_ready;

  typedef struct packed
  {
    logic                   v;
    rv_instr_u              instr;
    logic [`HZD_PIPE_W-1:0] pipe;
    logic                   irf_w;
    logic                   frf_w;
    logic                   mem_v;
  } disp_t;

  typedef struct packed
  {
    logic                       iv;
    logic [`HZD_REG_ADDR_W-1:0] ird;
    logic                       fv;
    logic [`HZD_REG_ADDR_W-1:0] frd;
  } late_t;

  // expected levels are dispatch_v_o and interrupt_v_o
  typedef struct packed
  {
    rv_instr_u   instr;
    logic [10:0] flags;
    disp_t       dsp;
    late_t       late;
    logic [7:0]  env;
    logic        exp_disp;
    logic        exp_irq;
  } row_t;

  localparam rv_instr_u no_instr = '0;
  localparam disp_t     no_disp  = '0;
  localparam late_t     no_late  = '0;

  logic                       clk_i;
  logic                       rst_n_i;
  logic [`HZD_INSTR_W-1:0]    isd_instr_i;
  logic                       isd_irs1_v_i;
  logic                       isd_irs2_v_i;
  logic                       isd_frs1_v_i;
  logic                       isd_frs2_v_i;
  logic                       isd_frs3_v_i;
  logic                       isd_iwb_v_i;
  logic                       isd_fwb_v_i;
  logic                       isd_mem_v_i;
  logic                       isd_fence_v_i;
  logic                       isd_csr_v_i;
  logic                       isd_long_v_i;
  logic                       disp_v_i;
  logic [`HZD_INSTR_W-1:0]    disp_instr_i;
  logic [`HZD_PIPE_W-1:0]     disp_pipe_i;
  logic                       disp_irf_w_i;
  logic                       disp_frf_w_i;
  logic                       disp_mem_v_i;
  logic                       iwb_late_v_i;
  logic [`HZD_REG_ADDR_W-1:0] iwb_rd_i;
  logic                       fwb_late_v_i;
  logic [`HZD_REG_ADDR_W-1:0] fwb_rd_i;
  logic                       cmd_full_i;
  logic                       credits_full_i;
  logic                       credits_empty_i;
  logic                       idiv_ready_i;
  logic                       fdiv_ready_i;
  logic                       mem_ready_i;
  logic                       ptw_busy_i;
  logic                       irq_pending_i;
  logic                       dispatch_v_o;
  logic                       interrupt_v_o;

  row_t rows[$];

  hzd_detector u_dut (.*);

  function automatic rv_instr_u rtype_of(input logic [`HZD_REG_ADDR_W-1:0] rd,
                                         input logic [`HZD_REG_ADDR_W-1:0] rs1,
                                         input logic [`HZD_REG_ADDR_W-1:0] rs2);
    rv_instr_u w;
    w = '0;
    w.rtype.opcode   = 7'h33;
    w.rtype.rd_addr  = rd;
    w.rtype.rs1_addr = rs1;
    w.rtype.rs2_addr = rs2;
    return w;
  endfunction

  // fused multiply-add word, rs3 lives in the upper five bits
  function automatic rv_instr_u r4_of(input logic [`HZD_REG_ADDR_W-1:0] rd,
                                      input logic [`HZD_REG_ADDR_W-1:0] rs1,
                                      input logic [`HZD_REG_ADDR_W-1:0] rs2,
                                      input logic [`HZD_REG_ADDR_W-1:0] rs3);
    rv_instr_u w;
    w = '0;
    w.r4type.opcode   = 7'h43;
    w.r4type.rd_addr  = rd;
    w.r4type.rs1_addr = rs1;
    w.r4type.rs2_addr = rs2;
    w.r4type.rs3_addr = rs3;
    return w;
  endfunction

  function automatic disp_t disp_of(input logic [`HZD_PIPE_W-1:0] pipe,
                                    input logic [`HZD_REG_ADDR_W-1:0] rd,
                                    input logic irf_w, input logic frf_w, input logic mem_v);
    disp_t d;
    d.v     = 1'b1;
    d.instr = rtype_of(rd, 5'd0, 5'd0);
    d.pipe  = pipe;
    d.irf_w = irf_w;
    d.frf_w = frf_w;
    d.mem_v = mem_v;
    return d;
  endfunction

  task automatic add_rows(input int count, input rv_instr_u instr, input logic [10:0] flags,
                          input disp_t dsp, input logic [7:0] env, input logic [1:0] expected);
    row_t r;
    r.instr    = instr;
    r.flags    = flags;
    r.dsp      = dsp;
    r.late     = no_late;
    r.env      = env;
    r.exp_disp = expected[1];
    r.exp_irq  = expected[0];
    for (int k = 0; k < count; k++)
      rows.push_back(r);
  endtask

  task automatic build_table();
    rv_instr_u rd_x5;
    rv_instr_u rd_x0;
    rv_instr_u rd_f3;
    rv_instr_u rd_x7;
    rv_instr_u wr_x7;
    disp_t     mul_x5;
    disp_t     mul_x0;
    disp_t     fma_f3;
    disp_t     long_x7;
    disp_t     int_op;
    disp_t     mem_op;
    rd_x5   = rtype_of(5'd6, 5'd5, 5'd0);
    rd_x0   = rtype_of(5'd6, 5'd0, 5'd0);
    rd_f3   = r4_of(5'd4, 5'd1, 5'd2, 5'd3);
    rd_x7   = rtype_of(5'd8, 5'd7, 5'd0);
    wr_x7   = rtype_of(5'd7, 5'd0, 5'd0);
    mul_x5  = disp_of(`HZD_PIPE_MUL, 5'd5, 1'b1, 1'b0, 1'b0);
    mul_x0  = disp_of(`HZD_PIPE_MUL, 5'd0, 1'b1, 1'b0, 1'b0);
    fma_f3  = disp_of(`HZD_PIPE_FMA, 5'd3, 1'b0, 1'b1, 1'b0);
    long_x7 = disp_of(`HZD_PIPE_LONG, 5'd7, 1'b1, 1'b0, 1'b0);
    int_op  = disp_of(`HZD_PIPE_INT, 5'd0, 1'b0, 1'b0, 1'b0);
    mem_op  = disp_of(`HZD_PIPE_MEM_EARLY, 5'd0, 1'b0, 1'b0, 1'b1);
    add_rows(1, no_instr, f_none, no_disp, env_idle, 2'b10);
    // mul result is not forwardable in record stages 0 and 1
    add_rows(1, no_instr, f_none, mul_x5, env_idle, 2'b10);
    add_rows(2, rd_x5, f_irs1 | f_irs2 | f_iwb, no_disp, env_idle, 2'b00);
    add_rows(1, rd_x5, f_irs1 | f_irs2 | f_iwb, no_disp, env_idle, 2'b10);
    add_rows(1, no_instr, f_none, mul_x0, env_idle, 2'b10);
    add_rows(2, rd_x0, f_irs1 | f_irs2, no_disp, env_idle, 2'b10);
    // fma stays busy through all three stages
    add_rows(1, no_instr, f_none, fma_f3, env_idle, 2'b10);
    add_rows(3, rd_f3, f_frs1 | f_frs2 | f_frs3 | f_fwb, no_disp, env_idle, 2'b00);
    add_rows(1, rd_f3, f_frs1 | f_frs2 | f_frs3 | f_fwb, no_disp, env_idle, 2'b10);
    // long op holds x7 until the late writeback
    add_rows(1, no_instr, f_none, long_x7, env_idle, 2'b10);
    add_rows(4, rd_x7, f_irs1 | f_iwb, no_disp, env_idle, 2'b00);
    add_rows(2, wr_x7, f_iwb, no_disp, env_idle, 2'b00);
    rows[rows.size()-1].late.iv  = 1'b1;
    rows[rows.size()-1].late.ird = 5'd7;
    add_rows(1, wr_x7, f_iwb, no_disp, env_idle, 2'b10);
    add_rows(1, rd_x7, f_irs1 | f_iwb, no_disp, env_idle, 2'b10);
    // control and structural hazards
    add_rows(1, no_instr, f_fence, no_disp, env_idle & ~e_cred_empty, 2'b00);
    add_rows(1, no_instr, f_fence, no_disp, env_idle, 2'b10);
    add_rows(1, no_instr, f_none, int_op, env_idle, 2'b10);
    add_rows(3, no_instr, f_csr, no_disp, env_idle, 2'b00);
    add_rows(1, no_instr, f_csr, no_disp, env_idle, 2'b10);
    add_rows(1, no_instr, f_mem, no_disp, env_idle & ~e_mem_ready, 2'b00);
    add_rows(1, no_instr, f_mem, no_disp, env_idle, 2'b10);
    add_rows(1, no_instr, f_mem, no_disp, env_idle | e_cred_full, 2'b00);
    add_rows(1, no_instr, f_long, no_disp, env_idle & ~e_idiv, 2'b00);
    add_rows(1, no_instr, f_long, no_disp, env_idle & ~e_fdiv, 2'b00);
    add_rows(1, no_instr, f_long, no_disp, env_idle, 2'b10);
    add_rows(1, no_instr, f_none, no_disp, env_idle | e_cmd_full, 2'b00);
    // fence waits while a memory op is in the record
    add_rows(1, no_instr, f_none, mem_op, env_idle, 2'b10);
    add_rows(3, no_instr, f_fence, no_disp, env_idle, 2'b00);
    add_rows(1, no_instr, f_fence, no_disp, env_idle, 2'b10);
    // interrupts are masked while the walker is busy
    add_rows(1, no_instr, f_none, no_disp, env_idle | e_irq, 2'b11);
    add_rows(1, no_instr, f_none, no_disp, env_idle | e_irq | e_ptw, 2'b00);
    add_rows(1, no_instr, f_none, no_disp, env_idle | e_ptw, 2'b00);
    add_rows(1, no_instr, f_none, no_disp, env_idle, 2'b10);
  endtask

  task automatic drive_row(input row_t r);
    isd_instr_i = r.instr;
    {isd_irs1_v_i, isd_irs2_v_i, isd_frs1_v_i, isd_frs2_v_i, isd_frs3_v_i, isd_iwb_v_i,
     isd_fwb_v_i, isd_mem_v_i, isd_fence_v_i, isd_csr_v_i, isd_long_v_i} = r.flags;
    disp_v_i     = r.dsp.v;
    disp_instr_i = r.dsp.instr;
    disp_pipe_i  = r.dsp.pipe;
    disp_irf_w_i = r.dsp.irf_w;
    disp_frf_w_i = r.dsp.frf_w;
    disp_mem_v_i = r.dsp.mem_v;
    iwb_late_v_i = r.late.iv;
    iwb_rd_i     = r.late.ird;
    fwb_late_v_i = r.late.fv;
    fwb_rd_i     = r.late.frd;
    {cmd_full_i, credits_full_i, credits_empty_i, idiv_ready_i, fdiv_ready_i, mem_ready_i,
     ptw_busy_i, irq_pending_i} = r.env;
  endtask

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_dispatch(input int row, input logic got, input logic expected);
    if (got !== expected)
    begin
      $display("Fail at time %0t, row %0d: dispatch_v_o is %b, expected %b",
               $time, row, got, expected);
      abort_run();
    end
  endtask

  task automatic check_interrupt(input int row, input logic got, input logic expected);
    if (got !== expected)
    begin
      $display("Fail at time %0t, row %0d: interrupt_v_o is %b, expected %b",
               $time, row, got, expected);
      abort_run();
    end
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever
      #50 clk_i = ~clk_i;
  end

  initial
  begin
    row_t idle;
    int   cyc;
    idle     = '0;
    idle.env = env_idle;
    rst_n_i  = 1'b0;
    drive_row(idle);
    build_table();
    cyc = 0;
    while (cyc < 3)
    begin
      @(posedge clk_i);
      cyc++;
    end
    #10;
    rst_n_i = 1'b1;
    cyc = 0;
    while (dispatch_v_o !== 1'b1)
    begin
      if (cyc == reset_timeout)
      begin
        $display("Timeout: dispatch_v_o stayed low after reset was released");
        abort_run();
      end
      @(negedge clk_i);
      cyc++;
    end
    // inputs change after the edge, outputs settle by the falling edge
    for (int idx = 0; idx < rows.size(); idx++)
    begin
      if (idx >= row_limit)
      begin
        $display("Timeout: the stimulus table ran past %0d rows", row_limit);
        abort_run();
      end
      @(posedge clk_i);
      #10;
      drive_row(rows[idx]);
      @(negedge clk_i);
      check_dispatch(idx, dispatch_v_o, rows[idx].exp_disp);
      check_interrupt(idx, interrupt_v_o, rows[idx].exp_irq);
    end
    @(posedge clk_i);
    $display("STATUS: PASS");
    $finish;
  end

endmodule
